// File: filelist.f
+incdir+source
source/doa_pkg.sv
source/centrosym_matrix.sv
source/correlation_mults.sv
source/adder_tree.sv
source/pre_acc_scale.sv
source/band_accumulator.sv
source/band_doa.sv
test/tb_band_doa.sv

// File: Bender.yml
package:
  name: band_doa

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/doa_pkg.sv
      - source/centrosym_matrix.sv
      - source/correlation_mults.sv
      - source/adder_tree.sv
      - source/pre_acc_scale.sv
      - source/band_accumulator.sv
      - source/band_doa.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_band_doa.sv

// File: test/tb_band_doa.sv
`include "doa_cfg.svh"

module tb_band_doa;
    import doa_pkg::*;

    localparam int VW          = `PARALLEL * `DIN_WIDTH;
    localparam int SHIFT       = 2 * `DIN_POINT - `ACC_POINT - `PRE_ACC_SHIFT;
    localparam longint SAT_MAX = (longint'(1) << (`ACC_WIDTH - 1)) - 1;
    localparam longint SAT_MIN = -(longint'(1) << (`ACC_WIDTH - 1));
    localparam int CYCLE_LIMIT = 20000;   // stimulus needs well under 4000

    logic          clk;
    logic          reset;
    logic [VW-1:0] din1_re;
    logic [VW-1:0] din1_im;
    logic [VW-1:0] din2_re;
    logic [VW-1:0] din2_im;
    logic          din_valid;
    logic          new_acc;
    acc_t          r11;
    acc_t          r22;
    acc_t          r12;
    logic          dout_valid;
    band_t         band_number;

    integer seed;
    int     cycle_count;
    string  test_name;

    // model state
    acc_t   model_r11 [`BANDS];
    acc_t   model_r22 [`BANDS];
    acc_t   model_r12 [`BANDS];
    logic   model_has_data;
    beat_t  model_beat;
    string  model_name;

    acc_t   exp_r11 [$];
    acc_t   exp_r22 [$];
    acc_t   exp_r12 [$];
    band_t  exp_band [$];
    string  exp_name [$];

    band_doa uut (
        .clk         (clk),
        .reset       (reset),
        .din1_re     (din1_re),
        .din1_im     (din1_im),
        .din2_re     (din2_re),
        .din2_im     (din2_im),
        .din_valid   (din_valid),
        .new_acc     (new_acc),
        .r11         (r11),
        .r22         (r22),
        .r12         (r12),
        .dout_valid  (dout_valid),
        .band_number (band_number)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic longint lane_sample(input logic [VW-1:0] v, input int i);
        sample_t s;
        s = v[i*`DIN_WIDTH +: `DIN_WIDTH];
        return longint'(s);
    endfunction

    function automatic acc_in_t scale_sum(input longint s);
        longint t;
        t = s >>> SHIFT;   // floor
        if (t > SAT_MAX) begin
            t = SAT_MAX;
        end else if (t < SAT_MIN) begin
            t = SAT_MIN;
        end
        return acc_in_t'(t);
    endfunction

    // expected scaled triple of one beat from the transform rules
    function automatic void ref_beat(input logic [VW-1:0] a_re, input logic [VW-1:0] a_im,
                                     input logic [VW-1:0] b_re, input logic [VW-1:0] b_im,
                                     output acc_in_t p1, output acc_in_t p2,
                                     output acc_in_t c);
        longint s1;
        longint s2;
        longint s3;
        longint y1r;
        longint y1i;
        longint y2r;
        longint y2i;
        s1 = 0;
        s2 = 0;
        s3 = 0;
        for (int i = 0; i < `PARALLEL; i++) begin
            y1r = lane_sample(a_re, i) + lane_sample(b_re, i);
            y1i = lane_sample(a_im, i) + lane_sample(b_im, i);
            y2r = lane_sample(a_im, i) - lane_sample(b_im, i);
            y2i = lane_sample(b_re, i) - lane_sample(a_re, i);
            s1 += y1r * y1r + y1i * y1i;
            s2 += y2r * y2r + y2i * y2i;
            s3 += y1r * y2r + y1i * y2i;
        end
        p1 = scale_sum(s1);
        p2 = scale_sum(s2);
        c  = scale_sum(s3);
    endfunction

    task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_band(input string name, input band_t expected, input band_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // model update for one beat in accumulator order
    task automatic model_beat_update(input logic [VW-1:0] a_re, input logic [VW-1:0] a_im,
                                     input logic [VW-1:0] b_re, input logic [VW-1:0] b_im,
                                     input logic na);
        acc_in_t p1;
        acc_in_t p2;
        acc_in_t c;
        int      band;
        ref_beat(a_re, a_im, b_re, b_im, p1, p2, c);
        if (na) begin
            if (model_has_data) begin
                for (int b = 0; b < `BANDS; b++) begin
                    exp_r11.push_back(model_r11[b]);
                    exp_r22.push_back(model_r22[b]);
                    exp_r12.push_back(model_r12[b]);
                    exp_band.push_back(band_t'(b));
                    exp_name.push_back(model_name);
                end
            end
            model_has_data = 1'b1;
            model_name     = test_name;
            model_beat     = '0;
            for (int b = 0; b < `BANDS; b++) begin
                model_r11[b] = '0;
                model_r22[b] = '0;
                model_r12[b] = '0;
            end
        end
        band = model_beat / `BEATS_PER_BAND;
        model_r11[band] = model_r11[band] + acc_t'(p1);
        model_r22[band] = model_r22[band] + acc_t'(p2);
        model_r12[band] = model_r12[band] + acc_t'(c);
        model_beat = model_beat + 1'b1;   // wraps every frame
    endtask

    task automatic send_idle();
        @(posedge clk);
        #10;
        din_valid = 1'b0;
        new_acc   = 1'b0;
    endtask

    task automatic send_beat(input logic [VW-1:0] a_re, input logic [VW-1:0] a_im,
                             input logic [VW-1:0] b_re, input logic [VW-1:0] b_im,
                             input logic na, input int gap);
        repeat (gap) send_idle();
        @(posedge clk);
        #10;
        din1_re   = a_re;
        din1_im   = a_im;
        din2_re   = b_re;
        din2_im   = b_im;
        din_valid = 1'b1;
        new_acc   = na;
        model_beat_update(a_re, a_im, b_re, b_im, na);
    endtask

    // kind 0 to 4 picks zero, one fixed lane, per band, full scale or random samples
    task automatic make_beat(input int kind, input int frame, input int beat,
                             output logic [VW-1:0] a_re, output logic [VW-1:0] a_im,
                             output logic [VW-1:0] b_re, output logic [VW-1:0] b_im);
        int k;
        int sh;
        k    = beat / `BEATS_PER_BAND;
        sh   = 2 * (frame % 2);   // odd random frames at quarter scale stay mostly unclamped
        a_re = '0;
        a_im = '0;
        b_re = '0;
        b_im = '0;
        for (int i = 0; i < `PARALLEL; i++) begin
            case (kind)
                1: if (i == 0) begin
                    a_re[0 +: `DIN_WIDTH] = sample_t'(3000);
                    a_im[0 +: `DIN_WIDTH] = sample_t'(-1200);
                    b_re[0 +: `DIN_WIDTH] = sample_t'(500);
                    b_im[0 +: `DIN_WIDTH] = sample_t'(2100);
                end
                2: begin
                    a_re[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'(900 * (k + 1) + 37 * i);
                    a_im[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'(-400 * (k + 1));
                    b_re[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'(250 * frame - 120 * i);
                    b_im[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'(1500 - 300 * k);
                end
                3: begin
                    a_re[i*`DIN_WIDTH +: `DIN_WIDTH] = 16'h7fff;
                    a_im[i*`DIN_WIDTH +: `DIN_WIDTH] = 16'h7fff;
                    b_re[i*`DIN_WIDTH +: `DIN_WIDTH] = 16'h7fff;
                    b_im[i*`DIN_WIDTH +: `DIN_WIDTH] = 16'h7fff;
                end
                4: begin
                    a_re[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'($random(seed)) >>> sh;
                    a_im[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'($random(seed)) >>> sh;
                    b_re[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'($random(seed)) >>> sh;
                    b_im[i*`DIN_WIDTH +: `DIN_WIDTH] = sample_t'($random(seed)) >>> sh;
                end
                default: ;
            endcase
        end
    endtask

    task automatic send_frame(input int kind, input int frame, input logic start,
                              input int beats, input int max_gap);
        logic [VW-1:0] a_re;
        logic [VW-1:0] a_im;
        logic [VW-1:0] b_re;
        logic [VW-1:0] b_im;
        int            gap;
        for (int b = 0; b < beats; b++) begin
            make_beat(kind, frame, b, a_re, a_im, b_re, b_im);
            gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
            send_beat(a_re, a_im, b_re, b_im, start && (b == 0), gap);
        end
    endtask

    task automatic apply_reset();
        repeat (20) send_idle();   // let the pipeline and any stream finish
        @(posedge clk);
        #10;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #10;
        reset          = 1'b0;
        model_has_data = 1'b0;
        model_beat     = '0;
    endtask

    // compare every streamed band against the model
    always @(negedge clk) begin
        if (!reset && dout_valid === 1'b1) begin
            if (exp_band.size() == 0) begin
                $display("dout_valid went high with no band totals expected");
                $display("TEST FAIL");
                $fatal(1);
            end else begin
                check_band({exp_name[0], " band_number"}, exp_band.pop_front(), band_number);
                check_acc({exp_name[0], " r11"}, exp_r11.pop_front(), r11);
                check_acc({exp_name[0], " r22"}, exp_r22.pop_front(), r22);
                check_acc({exp_name[0], " r12"}, exp_r12.pop_front(), r12);
                void'(exp_name.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    initial begin
        seed           = 32'h8de5_7a7f;
        cycle_count    = 0;
        reset          = 1'b1;
        din1_re        = '0;
        din1_im        = '0;
        din2_re        = '0;
        din2_im        = '0;
        din_valid      = 1'b0;
        new_acc        = 1'b0;
        model_has_data = 1'b0;
        model_beat     = '0;
        test_name      = "transform";
        repeat (3) @(posedge clk);
        #10;
        reset = 1'b0;

        send_frame(1, 0, 1'b1, `BEATS_PER_FRAME, 0);

        test_name = "band_split";
        for (int f = 0; f < 3; f++) begin
            send_frame(2, f, f == 0, `BEATS_PER_FRAME, 0);
        end

        test_name = "valid_gaps";
        for (int f = 0; f < 3; f++) begin
            send_frame(2, f, f == 0, `BEATS_PER_FRAME, 3);
        end

        test_name = "saturation";
        send_frame(3, 0, 1'b1, `BEATS_PER_FRAME, 0);

        // partial integration is thrown away by the reset
        test_name = "reset";
        send_frame(2, 5, 1'b1, 8, 0);
        apply_reset();
        send_frame(2, 1, 1'b1, `BEATS_PER_FRAME, 0);   // first one after reset stays silent
        send_frame(2, 2, 1'b1, `BEATS_PER_FRAME, 1);

        test_name = "random";
        for (int f = 0; f < 40; f++) begin
            send_frame(4, f, ({$random(seed)} % 3) == 0, `BEATS_PER_FRAME, 1);
        end
        send_frame(0, 0, 1'b1, 1, 0);   // closes the last integration

        repeat (20) send_idle();
        if (exp_band.size() != 0) begin
            $display("%0d expected band totals never came out", exp_band.size());
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: source/band_doa.sv
`include "doa_cfg.svh"

module band_doa (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`PARALLEL*`DIN_WIDTH-1:0] din1_re,
    input  logic [`PARALLEL*`DIN_WIDTH-1:0] din1_im,
    input  logic [`PARALLEL*`DIN_WIDTH-1:0] din2_re,
    input  logic [`PARALLEL*`DIN_WIDTH-1:0] din2_im,
    input  logic                            din_valid,
    input  logic                            new_acc,
    output doa_pkg::acc_t                   r11,
    output doa_pkg::acc_t                   r22,
    output doa_pkg::acc_t                   r12,
    output logic                            dout_valid,
    output doa_pkg::band_t                  band_number
);
    import doa_pkg::*;

    localparam int PW = $bits(product_t);

    wire [`PARALLEL*PW-1:0] pow1_lanes;
    wire [`PARALLEL*PW-1:0] pow2_lanes;
    wire [`PARALLEL*PW-1:0] corr_lanes;
    wire [`PARALLEL-1:0]    mult_valid;
    wire [`PARALLEL-1:0]    mult_new_acc;

    sum_t    pow1_sum;
    sum_t    pow2_sum;
    sum_t    corr_sum;
    logic    tree_valid;
    logic    tree_new_acc;
    acc_in_t pow1_acc;
    acc_in_t pow2_acc;
    acc_in_t corr_acc;
    logic    scale_valid;
    logic    scale_new_acc;

    for (genvar i = 0; i < `PARALLEL; i++) begin : lane
        lane_t y1_re;
        lane_t y1_im;
        lane_t y2_re;
        lane_t y2_im;
        logic  cs_valid;
        logic  cs_new_acc;

        centrosym_matrix centrosym_inst (
            .clk          (clk),
            .reset        (reset),
            .din1_re      (din1_re[i*`DIN_WIDTH +: `DIN_WIDTH]),
            .din1_im      (din1_im[i*`DIN_WIDTH +: `DIN_WIDTH]),
            .din2_re      (din2_re[i*`DIN_WIDTH +: `DIN_WIDTH]),
            .din2_im      (din2_im[i*`DIN_WIDTH +: `DIN_WIDTH]),
            .din_valid    (din_valid),
            .new_acc      (new_acc),
            .y1_re        (y1_re),
            .y1_im        (y1_im),
            .y2_re        (y2_re),
            .y2_im        (y2_im),
            .dout_valid   (cs_valid),
            .dout_new_acc (cs_new_acc)
        );

        correlation_mults mults_inst (
            .clk          (clk),
            .reset        (reset),
            .y1_re        (y1_re),
            .y1_im        (y1_im),
            .y2_re        (y2_re),
            .y2_im        (y2_im),
            .din_valid    (cs_valid),
            .new_acc      (cs_new_acc),
            .pow1         (pow1_lanes[i*PW +: PW]),
            .pow2         (pow2_lanes[i*PW +: PW]),
            .corr_re      (corr_lanes[i*PW +: PW]),
            .dout_valid   (mult_valid[i]),
            .dout_new_acc (mult_new_acc[i])
        );
    end

    // lanes run in lockstep, lane 0 strobes stand for all
    adder_tree tree_inst (
        .clk          (clk),
        .reset        (reset),
        .pow1         (pow1_lanes),
        .pow2         (pow2_lanes),
        .corr_re      (corr_lanes),
        .din_valid    (mult_valid[0]),
        .new_acc      (mult_new_acc[0]),
        .pow1_sum     (pow1_sum),
        .pow2_sum     (pow2_sum),
        .corr_sum     (corr_sum),
        .dout_valid   (tree_valid),
        .dout_new_acc (tree_new_acc)
    );

    pre_acc_scale scale_inst (
        .clk          (clk),
        .reset        (reset),
        .pow1_sum     (pow1_sum),
        .pow2_sum     (pow2_sum),
        .corr_sum     (corr_sum),
        .din_valid    (tree_valid),
        .new_acc      (tree_new_acc),
        .pow1_acc     (pow1_acc),
        .pow2_acc     (pow2_acc),
        .corr_acc     (corr_acc),
        .dout_valid   (scale_valid),
        .dout_new_acc (scale_new_acc)
    );

    band_accumulator acc_inst (
        .clk         (clk),
        .reset       (reset),
        .pow1_acc    (pow1_acc),
        .pow2_acc    (pow2_acc),
        .corr_acc    (corr_acc),
        .din_valid   (scale_valid),
        .new_acc     (scale_new_acc),
        .r11         (r11),
        .r22         (r22),
        .r12         (r12),
        .dout_valid  (dout_valid),
        .band_number (band_number)
    );

endmodule

// File: source/band_accumulator.sv
`include "doa_cfg.svh"

module band_accumulator (
    input  logic             clk,
    input  logic             reset,
    input  doa_pkg::acc_in_t pow1_acc,
    input  doa_pkg::acc_in_t pow2_acc,
    input  doa_pkg::acc_in_t corr_acc,
    input  logic             din_valid,
    input  logic             new_acc,
    output doa_pkg::acc_t    r11,
    output doa_pkg::acc_t    r22,
    output doa_pkg::acc_t    r12,
    output logic             dout_valid,
    output doa_pkg::band_t   band_number
);
    import doa_pkg::*;

    beat_t beat_cnt;
    beat_t cur_beat;
    band_t cur_band;
    logic  has_data;     // an integration is running
    logic  stream_busy;
    band_t stream_band;

    acc_t  int_r11 [`BANDS];
    acc_t  int_r22 [`BANDS];
    acc_t  int_r12 [`BANDS];
    acc_t  lat_r11 [`BANDS];
    acc_t  lat_r22 [`BANDS];
    acc_t  lat_r12 [`BANDS];

    // a new_acc beat is always beat 0 of its frame
    always_comb begin
        cur_beat = new_acc ? '0 : beat_cnt;
        cur_band = band_t'(cur_beat / `BEATS_PER_BAND);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt    <= '0;
            has_data    <= 1'b0;
            stream_busy <= 1'b0;
            stream_band <= '0;
            dout_valid  <= 1'b0;
        end else begin
            dout_valid <= stream_busy;
            if (stream_busy) begin
                stream_band <= stream_band + 1'b1;
                if (stream_band == band_t'(`BANDS - 1)) begin
                    stream_busy <= 1'b0;
                end
            end
            if (din_valid) begin
                beat_cnt <= cur_beat + 1'b1;   // wraps at frame end
                if (new_acc) begin
                    has_data <= 1'b1;
                    if (has_data) begin
                        stream_busy <= 1'b1;   // previous totals go out
                        stream_band <= '0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stream_busy) begin
            r11         <= lat_r11[stream_band];
            r22         <= lat_r22[stream_band];
            r12         <= lat_r12[stream_band];
            band_number <= stream_band;
        end
        if (din_valid) begin
            if (new_acc && has_data) begin
                lat_r11 <= int_r11;
                lat_r22 <= int_r22;
                lat_r12 <= int_r12;
            end
            // only the beat's band adds, new_acc restarts every band
            for (int b = 0; b < `BANDS; b++) begin
                if (band_t'(b) == cur_band) begin
                    int_r11[b] <= (new_acc ? acc_t'(0) : int_r11[b]) + acc_t'(pow1_acc);
                    int_r22[b] <= (new_acc ? acc_t'(0) : int_r22[b]) + acc_t'(pow2_acc);
                    int_r12[b] <= (new_acc ? acc_t'(0) : int_r12[b]) + acc_t'(corr_acc);
                end else if (new_acc) begin
                    int_r11[b] <= '0;
                    int_r22[b] <= '0;
                    int_r12[b] <= '0;
                end
            end
        end
    end

endmodule

// File: source/pre_acc_scale.sv
`include "doa_cfg.svh"

module pre_acc_scale (
    input  logic             clk,
    input  logic             reset,
    input  doa_pkg::sum_t    pow1_sum,
    input  doa_pkg::sum_t    pow2_sum,
    input  doa_pkg::sum_t    corr_sum,
    input  logic             din_valid,
    input  logic             new_acc,
    output doa_pkg::acc_in_t pow1_acc,
    output doa_pkg::acc_in_t pow2_acc,
    output doa_pkg::acc_in_t corr_acc,
    output logic             dout_valid,
    output logic             dout_new_acc
);
    import doa_pkg::*;

    // products carry 2*DIN_POINT fraction bits, the gain moves the point left
    localparam int   SCALE_SHIFT = 2 * `DIN_POINT - `ACC_POINT - `PRE_ACC_SHIFT;
    localparam sum_t SAT_HI      = (2 ** (`ACC_WIDTH - 1)) - 1;
    localparam sum_t SAT_LO      = -(2 ** (`ACC_WIDTH - 1));

    function automatic acc_in_t scale_sat(input sum_t value);
        sum_t shifted;
        shifted = value >>> SCALE_SHIFT;   // floor
        if (shifted > SAT_HI) begin
            return acc_in_t'(SAT_HI);
        end
        if (shifted < SAT_LO) begin
            return acc_in_t'(SAT_LO);
        end
        return acc_in_t'(shifted);
    endfunction

    always_ff @(posedge clk) begin
        pow1_acc <= scale_sat(pow1_sum);
        pow2_acc <= scale_sat(pow2_sum);
        corr_acc <= scale_sat(corr_sum);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dout_valid   <= 1'b0;
            dout_new_acc <= 1'b0;
        end else begin
            dout_valid   <= din_valid;
            dout_new_acc <= new_acc;
        end
    end

endmodule

// File: source/adder_tree.sv
`include "doa_cfg.svh"

module adder_tree (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [`PARALLEL*$bits(doa_pkg::product_t)-1:0] pow1,
    input  logic [`PARALLEL*$bits(doa_pkg::product_t)-1:0] pow2,
    input  logic [`PARALLEL*$bits(doa_pkg::product_t)-1:0] corr_re,
    input  logic                                         din_valid,
    input  logic                                         new_acc,
    output doa_pkg::sum_t                                pow1_sum,
    output doa_pkg::sum_t                                pow2_sum,
    output doa_pkg::sum_t                                corr_sum,
    output logic                                         dout_valid,
    output logic                                         dout_new_acc
);
    import doa_pkg::*;

    localparam int LEVELS = $clog2(`PARALLEL);
    localparam int PW     = $bits(product_t);

    logic [3*`PARALLEL*PW-1:0] leaves;
    logic [LEVELS-1:0]         valid_sr;
    logic [LEVELS-1:0]         flag_sr;

    assign leaves = {corr_re, pow2, pow1};   // quantity 0 is pow1, 2 is corr

    for (genvar l = 0; l < LEVELS; l++) begin : level
        localparam int W = PW + l + 1;          // one bit of growth per level
        localparam int N = `PARALLEL >> (l + 1);

        logic signed [W-2:0] src [3][2*N];
        logic signed [W-1:0] node [3][N];

        if (l == 0) begin : from_lanes
            for (genvar q = 0; q < 3; q++) begin : quantity
                for (genvar n = 0; n < 2 * N; n++) begin : lane
                    assign src[q][n] = leaves[(q*`PARALLEL+n)*PW +: PW];
                end
            end
        end else begin : from_level
            assign src = level[l-1].node;
        end

        always_ff @(posedge clk) begin
            for (int q = 0; q < 3; q++) begin
                for (int n = 0; n < N; n++) begin
                    node[q][n] <= W'(src[q][2*n]) + W'(src[q][2*n+1]);
                end
            end
        end
    end

    assign pow1_sum = level[LEVELS-1].node[0][0];
    assign pow2_sum = level[LEVELS-1].node[1][0];
    assign corr_sum = level[LEVELS-1].node[2][0];

    // valid and flag follow the tree depth
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
            flag_sr  <= '0;
        end else begin
            valid_sr <= LEVELS'({valid_sr, din_valid});
            flag_sr  <= LEVELS'({flag_sr, new_acc});
        end
    end

    assign dout_valid   = valid_sr[LEVELS-1];
    assign dout_new_acc = flag_sr[LEVELS-1];

endmodule

// File: source/correlation_mults.sv
module correlation_mults (
    input  logic              clk,
    input  logic              reset,
    input  doa_pkg::lane_t    y1_re,
    input  doa_pkg::lane_t    y1_im,
    input  doa_pkg::lane_t    y2_re,
    input  doa_pkg::lane_t    y2_im,
    input  logic              din_valid,
    input  logic              new_acc,
    output doa_pkg::product_t pow1,
    output doa_pkg::product_t pow2,
    output doa_pkg::product_t corr_re,
    output logic              dout_valid,
    output logic              dout_new_acc
);
    import doa_pkg::*;

    product_t re1_sq;
    product_t im1_sq;
    product_t re2_sq;
    product_t im2_sq;
    product_t re_cross;
    product_t im_cross;
    logic     mult_valid;
    logic     mult_new_acc;

    // stage 1: six signed products
    always_ff @(posedge clk) begin
        re1_sq   <= y1_re * y1_re;
        im1_sq   <= y1_im * y1_im;
        re2_sq   <= y2_re * y2_re;
        im2_sq   <= y2_im * y2_im;
        re_cross <= y1_re * y2_re;
        im_cross <= y1_im * y2_im;
    end

    // stage 2: powers and real part of the cross term
    always_ff @(posedge clk) begin
        pow1    <= re1_sq + im1_sq;
        pow2    <= re2_sq + im2_sq;
        corr_re <= re_cross + im_cross;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mult_valid   <= 1'b0;
            mult_new_acc <= 1'b0;
            dout_valid   <= 1'b0;
            dout_new_acc <= 1'b0;
        end else begin
            mult_valid   <= din_valid;
            mult_new_acc <= new_acc;
            dout_valid   <= mult_valid;
            dout_new_acc <= mult_new_acc;
        end
    end

endmodule

// File: source/centrosym_matrix.sv
module centrosym_matrix (
    input  logic             clk,
    input  logic             reset,
    input  doa_pkg::sample_t din1_re,
    input  doa_pkg::sample_t din1_im,
    input  doa_pkg::sample_t din2_re,
    input  doa_pkg::sample_t din2_im,
    input  logic             din_valid,
    input  logic             new_acc,
    output doa_pkg::lane_t   y1_re,
    output doa_pkg::lane_t   y1_im,
    output doa_pkg::lane_t   y2_re,
    output doa_pkg::lane_t   y2_im,
    output logic             dout_valid,
    output logic             dout_new_acc
);
    import doa_pkg::*;

    // unitary transform of the pair: y1 = x1 + x2, y2 = -j(x1 - x2)
    // the -j turns the difference into a real-valued rotation
    always_ff @(posedge clk) begin
        y1_re <= lane_t'(din1_re) + lane_t'(din2_re);
        y1_im <= lane_t'(din1_im) + lane_t'(din2_im);
        y2_re <= lane_t'(din1_im) - lane_t'(din2_im);   // imag of difference
        y2_im <= lane_t'(din2_re) - lane_t'(din1_re);   // negated real
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dout_valid   <= 1'b0;
            dout_new_acc <= 1'b0;
        end else begin
            dout_valid   <= din_valid;
            dout_new_acc <= din_valid & new_acc;   // flag only counts on a beat
        end
    end

endmodule

// File: source/doa_pkg.sv
`include "doa_cfg.svh"

package doa_pkg;

    // one component of an antenna sample
    typedef logic signed [`DIN_WIDTH-1:0] sample_t;

    // transformed component, one bit of growth from the add
    typedef logic signed [`DIN_WIDTH:0] lane_t;

    // square or cross term, plus one bit for the sum of two
    typedef logic signed [2*(`DIN_WIDTH+1):0] product_t;

    // lane sum, one bit per tree level
    typedef logic signed [2*(`DIN_WIDTH+1)+$clog2(`PARALLEL):0] sum_t;

    typedef logic signed [`ACC_WIDTH-1:0] acc_in_t;
    typedef logic signed [`DOUT_WIDTH-1:0] acc_t;

    typedef logic [$clog2(`BANDS)-1:0] band_t;
    typedef logic [$clog2(`BEATS_PER_FRAME)-1:0] beat_t;

endpackage

// File: source/doa_cfg.svh
`ifndef DOA_CFG_SVH
`define DOA_CFG_SVH

// input samples from the FFT
`define DIN_WIDTH       16
`define DIN_POINT       14

// lanes per beat and frame geometry
`define PARALLEL        4
`define VECTOR_LEN      64
`define BANDS           4

// gain before integration, powers of two
`define PRE_ACC_SHIFT   2

// accumulator input format
`define ACC_WIDTH       20
`define ACC_POINT       16

// integrator and output width
`define DOUT_WIDTH      32

`define BEATS_PER_FRAME (`VECTOR_LEN / `PARALLEL)
`define BEATS_PER_BAND  (`BEATS_PER_FRAME / `BANDS)

`endif
